// ==== Makefile ====
# Verilator flow for the cartridge testbench

VERILATOR ?= verilator
TOP       ?= tb_pce_cart
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the testbench printed the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/cart_loader.sv ====
`timescale 1ns/1ps
/*
 * Cartridge loader
 * Turns host download words into ROM store writes and inspects the
 * image for SuperGrafx, a copier header and the Populous signature
 */
`include "pce_cart_params.svh"

module cart_loader import pce_cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  dl_word_t   dl,
	input  logic       swap_bits,
	output logic       ioctl_wait,
	output store_wr_t  wr,
	input  logic       wr_ack,
	output cart_info_t info
);

	localparam int BAW = `PCE_BYTE_AW;
	localparam logic [BAW-1:0] WIN_NH = `PCE_POP_BASE_NH;
	localparam logic [BAW-1:0] WIN_H  = `PCE_POP_BASE_H;

	logic           cart_dl;    // Image transfer, not a cheat code
	logic           old_dl;
	logic [BAW-1:0] addr;       // Byte address of the current word
	logic           req;
	logic [15:0]    word;       // Incoming word after optional swap
	logic [15:0]    wr_data;
	logic           in_win;
	logic           sig_ok;
	logic [1:0]     populous;   // [0] headerless window, [1] header window
	logic           sgx;

	// Bit order reversed inside each byte
	function automatic logic [15:0] swap_word(input logic [15:0] d);
		logic [15:0] r;
		for (int i = 0; i < 8; i++) begin
			r[i]     = d[7 - i];
			r[8 + i] = d[15 - i];
		end
		return r;
	endfunction

	assign cart_dl = dl.download && (dl.index != `PCE_CODE_INDEX);
	assign word    = swap_bits ? swap_word(dl.data) : dl.data;

	// ============================================================
	// Signature inspection
	// ============================================================
	assign in_win = (addr[BAW-1:4] == WIN_NH[BAW-1:4]) ||
	                (addr[BAW-1:4] == WIN_H[BAW-1:4]);

	always_comb begin
		case (addr[3:0])
			4'd6:    sig_ok = (word == `PCE_POP_SIG0);
			4'd8:    sig_ok = (word == `PCE_POP_SIG1);
			4'd10:   sig_ok = (word == `PCE_POP_SIG2);
			4'd12:   sig_ok = (word == `PCE_POP_SIG3);
			default: sig_ok = 1'b1;   // Outside the signature slots
		endcase
	end

	// ============================================================
	// Download sequencing
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_dl     <= 1'b0;
			ioctl_wait <= 1'b0;
			req        <= 1'b0;
			addr       <= '0;
			populous   <= 2'b00;
			sgx        <= 1'b0;
		end else begin
			old_dl <= cart_dl;
			if (cart_dl && !old_dl) begin
				// New image
				addr     <= '0;
				populous <= 2'b11;
				sgx      <= (dl.index[4:0] == `PCE_SGX_INDEX);
			end else if (dl.wr && cart_dl) begin
				ioctl_wait <= 1'b1;
				req        <= ~req;   // Hand the word to the store
				if (in_win && !sig_ok)
					populous[addr[13]] <= 1'b0;   // Bit 13 tells the windows apart
			end else if (ioctl_wait && (req == wr_ack)) begin
				ioctl_wait <= 1'b0;
				addr       <= addr + BAW'(2);
			end
		end
	end

	// Word held for the store until the ack
	always_ff @(posedge clk_sys) begin
		if (dl.wr && cart_dl)
			wr_data <= word;
	end

	assign wr.addr = addr[BAW-1:1];
	assign wr.data = wr_data;
	assign wr.req  = req;

	// Odd number of 512 byte blocks means a copier header
	assign info.sgx      = sgx;
	assign info.header   = addr[9];
	assign info.populous = populous[addr[9]];

endmodule

// ==== rtl/cheat_code_loader.sv ====
`timescale 1ns/1ps
/*
 * Cheat code loader
 * Collects eight download halfwords into one cheat code record
 */
`include "pce_cart_params.svh"

module cheat_code_loader import pce_cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  dl_word_t    dl,
	output cheat_code_t code,
	output logic        code_valid
);

	logic code_wr;
	logic last_word;

	// Code transfers only, even offsets carry the words
	assign code_wr = dl.download && dl.wr &&
	                 (dl.index == `PCE_CODE_INDEX) && !dl.addr[0];

	// Offset 14 closes the record
	assign last_word = (dl.addr[3:0] == 4'd14);

	// Halfword view lines up with the byte offset in the record
	always_ff @(posedge clk_sys) begin
		if (code_wr)
			code.hw[dl.addr[3:1]] <= dl.data;
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && last_word;   // Single cycle pulse
	end

endmodule

// ==== rtl/pce_cart_params.svh ====
/*
 * PC Engine cartridge parameters
 * Widths, image offsets, download indices and signature words
 */
`ifndef PCE_CART_PARAMS_SVH
`define PCE_CART_PARAMS_SVH

// ============================================================
// Address widths
// ============================================================
`define PCE_BYTE_AW      14        // Byte address of the ROM image
`define PCE_WORD_AW      13        // Word address of the store

// ============================================================
// Image layout
// ============================================================
`define PCE_HDR_OFS      'h200     // Copier header skipped on reads
`define PCE_CODE_INDEX   8'hFF     // Download index of cheat codes
`define PCE_SGX_INDEX    5'd2      // Low index bits of a SuperGrafx image

// Signature windows, without and with header
`define PCE_POP_BASE_NH  'h1F20
`define PCE_POP_BASE_H   'h2120

// Populous signature at window offsets 6, 8, 10 and 12
`define PCE_POP_SIG0     16'h4F50
`define PCE_POP_SIG1     16'h5550
`define PCE_POP_SIG2     16'h4F4C
`define PCE_POP_SIG3     16'h5355

`endif

// ==== rtl/pce_cart_pkg.sv ====
/*
 * PC Engine cartridge types
 * Download beat, store write, image info, console read and cheat code
 */
`include "pce_cart_params.svh"

package pce_cart_pkg;

	// ============================================================
	// Host download stream
	// ============================================================
	typedef struct packed {
		logic                     download;  // Level, high for a whole transfer
		logic [7:0]               index;     // Image type or code index
		logic                     wr;        // One cycle per word
		logic [`PCE_BYTE_AW-1:0]  addr;      // Byte address of the word
		logic [15:0]              data;
	} dl_word_t;

	// Loader to store write, req toggles once per word
	typedef struct packed {
		logic [`PCE_WORD_AW-1:0]  addr;
		logic [15:0]              data;
		logic                     req;
	} store_wr_t;

	// Properties found while loading the image
	typedef struct packed {
		logic sgx;        // SuperGrafx image
		logic header;     // 512 byte copier header present
		logic populous;   // Signature found in the active window
	} cart_info_t;

	// ============================================================
	// Console side
	// ============================================================
	typedef struct packed {
		logic                     strobe;
		logic [`PCE_BYTE_AW-1:0]  addr;
	} rom_rd_t;

	// ============================================================
	// Cheat codes
	// ============================================================

	// Flags sit at the bottom so the halfword view runs in load order
	typedef struct packed {
		logic [31:0] replace;   // Halfwords 7 and 6
		logic [31:0] compare;   // Halfwords 5 and 4
		logic [31:0] addr;      // Halfwords 3 and 2
		logic [31:0] flags;     // Halfwords 1 and 0
	} cheat_fields_t;

	// Same record seen as raw download halfwords or as decoded fields
	typedef union packed {
		logic [7:0][15:0] hw;   // hw[k] is the word at byte offset 2k
		cheat_fields_t    f;
	} cheat_code_t;

endpackage

// ==== rtl/pce_cart_top.sv ====
`timescale 1ns/1ps
/*
 * PC Engine cartridge top
 * Download loader, ROM store, console reader and cheat code loader
 */
`include "pce_cart_params.svh"

module pce_cart_top import pce_cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst,
	input  dl_word_t    dl,
	input  logic        swap_bits,
	output logic        ioctl_wait,
	input  rom_rd_t     rd,
	output logic        rom_rdy,
	output logic [7:0]  rom_data,
	output cart_info_t  info,
	output cheat_code_t code,
	output logic        code_valid
);

	store_wr_t               wr;
	logic                    wr_ack;
	logic                    st_en;
	logic [`PCE_WORD_AW-1:0] st_addr;
	logic [15:0]             st_data;

	// ============================================================
	// Image path
	// ============================================================
	cart_loader cart_loader_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.dl         (dl),
		.swap_bits  (swap_bits),
		.ioctl_wait (ioctl_wait),
		.wr         (wr),
		.wr_ack     (wr_ack),
		.info       (info)
	);

	rom_store rom_store_i (
		.clk_sys (clk_sys),
		.rst     (rst),
		.wr      (wr),
		.wr_ack  (wr_ack),
		.rd_en   (st_en),
		.rd_addr (st_addr),
		.rd_data (st_data)
	);

	rom_reader rom_reader_i (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.rd       (rd),
		.info     (info),
		.st_en    (st_en),
		.st_addr  (st_addr),
		.st_data  (st_data),
		.rom_rdy  (rom_rdy),
		.rom_data (rom_data)
	);

	// Cheat codes share the download stream
	cheat_code_loader cheat_code_loader_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.dl         (dl),
		.code       (code),
		.code_valid (code_valid)
	);

endmodule

// ==== rtl/rom_reader.sv ====
`timescale 1ns/1ps
/*
 * ROM reader
 * Serves console byte reads from the word store, skipping the
 * copier header when the image has one
 */
`include "pce_cart_params.svh"

module rom_reader import pce_cart_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  rom_rd_t                 rd,
	input  cart_info_t              info,
	output logic                    st_en,
	output logic [`PCE_WORD_AW-1:0] st_addr,
	input  logic [15:0]             st_data,
	output logic                    rom_rdy,
	output logic [7:0]              rom_data
);

	localparam int BAW = `PCE_BYTE_AW;
	localparam logic [BAW-1:0] HDR_OFS = `PCE_HDR_OFS;

	logic [BAW-1:0] byte_addr;   // Image byte address after header skip
	logic           busy;        // Store data arrives this cycle
	logic           odd_q;

	assign byte_addr = rd.addr + (info.header ? HDR_OFS : '0);

	// Strobes are taken only while ready
	assign st_en   = rd.strobe && rom_rdy;
	assign st_addr = byte_addr[BAW-1:1];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_rdy <= 1'b1;
			busy    <= 1'b0;
		end else begin
			busy <= st_en;
			if (st_en)
				rom_rdy <= 1'b0;
			else if (busy)
				rom_rdy <= 1'b1;   // Data lands together with ready
		end
	end

	// Byte lane select, odd bytes in the upper half
	always_ff @(posedge clk_sys) begin
		if (st_en)
			odd_q <= byte_addr[0];
		if (busy)
			rom_data <= odd_q ? st_data[15:8] : st_data[7:0];
	end

endmodule

// ==== rtl/rom_store.sv ====
`timescale 1ns/1ps
/*
 * ROM store
 * Word memory for the cartridge image, toggle handshake write port
 * and registered read port
 */
`include "pce_cart_params.svh"

module rom_store import pce_cart_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  store_wr_t               wr,
	output logic                    wr_ack,
	input  logic                    rd_en,
	input  logic [`PCE_WORD_AW-1:0] rd_addr,
	output logic [15:0]             rd_data
);

	localparam int DEPTH = 1 << `PCE_WORD_AW;

	logic [15:0] mem [0:DEPTH-1];

	// Ack follows the request one cycle behind
	always_ff @(posedge clk_sys) begin
		if (rst)
			wr_ack <= 1'b0;
		else
			wr_ack <= wr.req;
	end

	// A pending toggle means a new word
	always_ff @(posedge clk_sys) begin
		if (wr.req != wr_ack)
			mem[wr.addr] <= wr.data;
	end

	always_ff @(posedge clk_sys) begin
		if (rd_en)
			rd_data <= mem[rd_addr];   // One cycle read latency
	end

endmodule

// ==== sim/cart_golden.txt ====
# Load: L index words swap sig exp_sgx exp_header exp_populous reads (all hex)
# Code: C hw0 .. hw7 exp_flags exp_addr exp_compare exp_replace (all hex)

# Headerless image with the signature, plain and swapped
L 00 1000 0 1 0 0 1 20
L 00 1000 1 1 0 0 1 20

# SuperGrafx index, copier header, broken signature in the upper window
L 02 1100 0 0 1 1 0 20

# Copier header with the signature in the upper window
L 01 1100 1 1 0 1 1 20

# SuperGrafx headerless image, broken signature
L 22 1000 1 0 1 0 0 18

# Cheat code records
C 0001 0000 2A10 0001 0055 0000 00FF 0000 00000001 00012A10 00000055 000000FF
C 0000 0000 F000 001F 0000 0000 0099 0000 00000000 001FF000 00000000 00000099
C 0003 8000 1FFE 0000 C0DE 0000 BEEF 1234 80000003 00001FFE 0000C0DE 1234BEEF

// ==== sim/tb_pce_cart.sv ====
`timescale 1ns/1ps
/*
 * Cartridge testbench
 * Replays golden load and cheat code scenarios against the cartridge top
 */
`include "pce_cart_params.svh"

module tb_pce_cart import pce_cart_pkg::*; ();

	localparam int RECHECK = 8;   // Reads after the cheat codes

	typedef struct packed {
		logic [7:0]  index;
		logic [15:0] words;
		logic        swap;
		logic        sig;     // Signature planted intact
		cart_info_t  exp;
		logic [15:0] reads;
	} load_rec_t;

	typedef struct packed {
		cheat_code_t words;   // Halfwords as sent
		cheat_code_t exp;     // Fields from the golden record
	} code_rec_t;

	logic        clk_sys;
	logic        rst;
	dl_word_t    dl;
	logic        swap_bits;
	logic        ioctl_wait;
	rom_rd_t     rd;
	logic        rom_rdy;
	logic [7:0]  rom_data;
	cart_info_t  info;
	cheat_code_t code;
	logic        code_valid;

	load_rec_t   loads[$];
	code_rec_t   codes[$];
	logic [7:0]  img [0:(1 << `PCE_BYTE_AW) - 1];   // Expected image bytes
	cart_info_t  last_info;
	int          last_span;
	integer      seed = 32'h627d_6a7b;
	int          value_errors = 0;
	int          proto_errors = 0;
	int          cycles = 0;
	int          limit = 0;

	pce_cart_top pce_cart_top_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.dl         (dl),
		.swap_bits  (swap_bits),
		.ioctl_wait (ioctl_wait),
		.rd         (rd),
		.rom_rdy    (rom_rdy),
		.rom_data   (rom_data),
		.info       (info),
		.code       (code),
		.code_valid (code_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR %0t %s: expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic check_info(input cart_info_t exp);
		if (info !== exp) begin
			value_errors++;
			$display("ERR %0t info: expected sgx %b header %b populous %b, got %b %b %b",
			         $time, exp.sgx, exp.header, exp.populous,
			         info.sgx, info.header, info.populous);
		end
	endtask

	task automatic check_byte(input logic [13:0] a, input logic [7:0] exp);
		if (rom_data !== exp) begin
			value_errors++;
			$display("ERR %0t rom_data at 0x%h: expected %h, got %h", $time, a, exp, rom_data);
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR %0t code.%s: expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_code(input cheat_code_t exp);
		check_field("flags", code.f.flags, exp.f.flags);
		check_field("addr", code.f.addr, exp.f.addr);
		check_field("compare", code.f.compare, exp.f.compare);
		check_field("replace", code.f.replace, exp.f.replace);
	endtask

	// ============================================================
	// Golden file and image helpers
	// ============================================================
	task automatic read_golden();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [12];
		load_rec_t   lr;
		code_rec_t   cr;
		fd = $fopen("sim/cart_golden.txt", "r");
		if (fd == 0) begin
			proto_errors++;
			$display("Cannot open sim/cart_golden.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line[0] == "#")
				continue;
			if (line[0] == "L") begin
				n = $sscanf(line, "L %h %h %h %h %h %h %h %h",
				            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
				lr.index        = f[0][7:0];
				lr.words        = f[1][15:0];
				lr.swap         = f[2][0];
				lr.sig          = f[3][0];
				lr.exp.sgx      = f[4][0];
				lr.exp.header   = f[5][0];
				lr.exp.populous = f[6][0];
				lr.reads        = f[7][15:0];
				if (n == 8)
					loads.push_back(lr);
				else begin
					proto_errors++;
					$display("Malformed load record in golden file: %s", line);
				end
			end else begin
				n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h",
				            f[0], f[1], f[2], f[3], f[4], f[5],
				            f[6], f[7], f[8], f[9], f[10], f[11]);
				cr.words.hw = {f[7][15:0], f[6][15:0], f[5][15:0], f[4][15:0],
				               f[3][15:0], f[2][15:0], f[1][15:0], f[0][15:0]};
				cr.exp.f.flags   = f[8];
				cr.exp.f.addr    = f[9];
				cr.exp.f.compare = f[10];
				cr.exp.f.replace = f[11];
				if (n == 12)
					codes.push_back(cr);
				else begin
					proto_errors++;
					$display("Malformed code record in golden file: %s", line);
				end
			end
		end
		$fclose(fd);
	endtask

	function automatic int run_limit();
		int total;
		total = 500;   // Reset, download edges and slack
		foreach (loads[i])
			total += 4 * int'(loads[i].words) + 3 * int'(loads[i].reads);
		total += 4 * 8 * codes.size() + 3 * RECHECK;
		return total;
	endfunction

	function automatic logic [15:0] sig_word(input int slot);
		logic [15:0] w;
		case (slot)
			0:       w = `PCE_POP_SIG0;
			1:       w = `PCE_POP_SIG1;
			2:       w = `PCE_POP_SIG2;
			default: w = `PCE_POP_SIG3;
		endcase
		return w;
	endfunction

	// Overwrites w when byte address b is a signature slot of the window
	function automatic void plant_sig(input int b, input int base, input logic good,
	                                  inout logic [15:0] w);
		int ofs;
		ofs = b - base;
		if (ofs >= 6 && ofs <= 12) begin
			w = sig_word((ofs - 6) / 2);
			if (!good && ofs == 12)
				w = w ^ 16'h0001;   // Broken last slot
		end
	endfunction

	// Each byte sent with its bits in reverse order
	function automatic logic [15:0] reverse_bytes(input logic [15:0] w);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = w[7:0];
		hi = w[15:8];
		lo = {<<{lo}};
		hi = {<<{hi}};
		return {hi, lo};
	endfunction

	// ============================================================
	// Bus tasks
	// ============================================================
	task automatic write_word(input logic [13:0] a, input logic [15:0] d);
		int n;
		@(posedge clk_sys);
		dl.wr   <= 1'b1;
		dl.addr <= a;
		dl.data <= d;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(negedge clk_sys);
		if (ioctl_wait !== 1'b1) begin
			proto_errors++;
			$display("ioctl_wait did not rise after the write to 0x%h at %0t", a, $time);
		end
		n = 1;
		while (ioctl_wait !== 1'b0 && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (n > 3) begin
			proto_errors++;
			$display("ioctl_wait stayed high %0d cycles after the write to 0x%h", n, a);
		end
	endtask

	task automatic read_byte(input logic [13:0] a, input logic [7:0] exp);
		int n;
		@(posedge clk_sys);
		rd.strobe <= 1'b1;
		rd.addr   <= a;
		@(posedge clk_sys);
		rd.strobe <= 1'b0;
		@(negedge clk_sys);
		n = 1;
		while (rom_rdy !== 1'b1 && n < 6) begin
			@(negedge clk_sys);
			n++;
		end
		if (n != 2) begin
			proto_errors++;
			$display("rom_rdy came back %0d cycles after the strobe at 0x%h, not 2", n, a);
		end
		check_byte(a, exp);
	endtask

	task automatic random_reads(input int count);
		logic [31:0] rnd;
		int          ofs;
		int          a;
		ofs = last_info.header ? `PCE_HDR_OFS : 0;
		repeat (count) begin
			rnd = $random(seed);
			a   = int'(rnd % 32'(last_span - ofs));
			read_byte(14'(a), img[14'(a + ofs)]);
		end
	endtask

	task automatic load_image(input load_rec_t r);
		int          b;
		logic [15:0] stored;
		@(posedge clk_sys);
		swap_bits   <= r.swap;
		dl.download <= 1'b1;
		dl.index    <= r.index;
		for (int w = 0; w < int'(r.words); w++) begin
			b      = 2 * w;
			stored = 16'($random(seed));
			if (r.exp.header) begin
				plant_sig(b, `PCE_POP_BASE_NH, 1'b0, stored);   // Broken copy in the lower window
				plant_sig(b, `PCE_POP_BASE_H, r.sig, stored);
			end else
				plant_sig(b, `PCE_POP_BASE_NH, r.sig, stored);
			img[14'(b)]     = stored[7:0];
			img[14'(b + 1)] = stored[15:8];
			write_word(14'(b), r.swap ? reverse_bytes(stored) : stored);
		end
		@(posedge clk_sys);
		dl.download <= 1'b0;
		@(negedge clk_sys);
		check_info(r.exp);
		last_info = r.exp;
		last_span = 2 * int'(r.words);
		random_reads(int'(r.reads));
	endtask

	task automatic send_code(input code_rec_t r);
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.index    <= `PCE_CODE_INDEX;
		for (int k = 0; k < 8; k++) begin
			@(posedge clk_sys);
			dl.wr   <= 1'b1;
			dl.addr <= 14'(2 * k);
			dl.data <= r.words.hw[3'(k)];
			@(posedge clk_sys);
			dl.wr <= 1'b0;
			@(negedge clk_sys);
			check_level("code_valid", code_valid, k == 7);
			check_level("ioctl_wait", ioctl_wait, 1'b0);   // Loader ignores codes
		end
		check_code(r.exp);
		@(negedge clk_sys);
		check_level("code_valid", code_valid, 1'b0);
		@(posedge clk_sys);
		dl.download <= 1'b0;
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial begin
		dl        = '0;
		rd        = '0;
		swap_bits = 1'b0;
		rst       = 1'b1;
		read_golden();
		if (loads.size() == 0) begin
			proto_errors++;
			$display("Golden file holds no load records");
		end
		limit = run_limit();
		repeat (3) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		check_level("ioctl_wait", ioctl_wait, 1'b0);
		check_level("code_valid", code_valid, 1'b0);
		check_level("rom_rdy", rom_rdy, 1'b1);
		foreach (loads[i])
			load_image(loads[i]);
		foreach (codes[i])
			send_code(codes[i]);
		if (loads.size() > 0) begin
			@(negedge clk_sys);
			check_info(last_info);   // Codes leave the image alone
			random_reads(RECHECK);
		end
		$display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout, the run did not end within %0d cycles", limit);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/pce_cart_pkg.sv
rtl/cart_loader.sv
rtl/rom_store.sv
rtl/rom_reader.sv
rtl/cheat_code_loader.sv
rtl/pce_cart_top.sv
sim/tb_pce_cart.sv
